/* flist.f */
+incdir+common
common/bridge_pkg.sv
save/save_ram.sv
save/save_unloader.sv
logic/bridge_loader.sv
logic/config_regs.sv
logic/bridge_read_mux.sv
logic/core_bridge_top.sv
testbench/tb_core_bridge.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       ?= tb_core_bridge
FLIST     ?= flist.f

SIM := obj_dir/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST)

# prints the simulation output and fails unless the pass message shows up
run: compile
	./$(SIM) | awk '{ print } /Everything OK/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf obj_dir

/* testbench/tb_core_bridge.sv */
// testbench for core_bridge_top, random traffic from a fixed seed
// accesses are 16 cycles apart since the bridge has no back pressure
// save contents are only read back at offsets written earlier
`timescale 1ns/1ps
`include "bridge_params.svh"

module tb_core_bridge;

  import bridge_pkg::*;

  // accesses per test, these size the watchdog
  localparam int n_save     = 24;
  localparam int n_rom      = 16;
  localparam int n_type     = 6;
  localparam int n_size     = 8;
  localparam int n_recheck  = 8;
  localparam int n_accesses = 2 * n_save + n_rom + 3 * n_type + 3 * n_size + n_recheck;
  localparam int timeout_ns = 2 * n_accesses * 16 * 4;

  logic        clk_74a = 1'b0;
  logic        reset_n;
  bridge_req_t bridge_req;
  logic [3:0]  sram_size;
  logic [31:0] bridge_rd_data;
  rom_write_t  rom_write;
  rom_type_t   rom_type;

  integer      seed;
  int          checks;
  int          errors;
  int          test_checks;
  int          test_errors;

  // model state
  logic [15:0] save_model [int];
  logic [27:0] save_locs [$];
  rom_write_t  rom_exp [$];
  rom_write_t  rom_head;
  rom_type_t   rom_type_model;

  core_bridge_top u_core_bridge_top (
    .clk_74a        (clk_74a),
    .reset_n        (reset_n),
    .bridge_req     (bridge_req),
    .sram_size      (sram_size),
    .bridge_rd_data (bridge_rd_data),
    .rom_write      (rom_write),
    .rom_type       (rom_type)
  );

  always #2 clk_74a = ~clk_74a;

  //////////////////////////////////////////////////////////////////////
  // bridge accesses, each 16 cycles, ending on a falling edge
  //////////////////////////////////////////////////////////////////////

  task automatic bus_write(input logic [31:0] addr, input logic [31:0] data);
    @(posedge clk_74a);
    bridge_req <= '{addr: addr, rd: 1'b0, wr: 1'b1, wr_data: data};
    @(posedge clk_74a);
    bridge_req <= '0;
    repeat (14) @(posedge clk_74a);
    @(negedge clk_74a);
  endtask

  // data sampled eight cycles after the read
  task automatic bus_read(input logic [31:0] addr, output logic [31:0] data);
    @(posedge clk_74a);
    bridge_req <= '{addr: addr, rd: 1'b1, wr: 1'b0, wr_data: 32'd0};
    @(posedge clk_74a);
    bridge_req <= '0;
    repeat (7) @(posedge clk_74a);
    @(negedge clk_74a);
    data = bridge_rd_data;
    repeat (7) @(posedge clk_74a);
    @(negedge clk_74a);
  endtask

  //////////////////////////////////////////////////////////////////////
  // compare tasks
  //////////////////////////////////////////////////////////////////////

  task automatic check_rd_data(input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Error: bridge_rd_data got %h expected %h", got, exp);
    end
  endtask

  task automatic check_rom_write(input rom_write_t got, input rom_write_t exp);
    logic bad;
    checks++;
    // idle port, address and data are don't care
    bad = exp.en ? (got !== exp) : (got.en !== 1'b0);
    if (bad) begin
      errors++;
      $display("Error: rom_write got en %h addr %h data %h", got.en, got.addr, got.data);
      $display("       expected en %h addr %h data %h", exp.en, exp.addr, exp.data);
    end
  endtask

  task automatic check_rom_type(input rom_type_t got, input rom_type_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Error: rom_type got %h expected %h", got, exp);
    end
  endtask

  // every rom pulse must be one the model expects
  always @(negedge clk_74a) begin
    if (reset_n === 1'b1 && rom_write.en === 1'b1) begin
      if (rom_exp.size() == 0) begin
        errors++;
        $display("rom_write pulsed at %0t ns with no write expected", $time);
      end else begin
        rom_head = rom_exp.pop_front();
        check_rom_write(rom_write, rom_head);
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // model helpers and per test counts
  //////////////////////////////////////////////////////////////////////

  // big endian, upper halfword at the word offset
  task automatic write_save_word(input logic [27:0] loc, input logic [31:0] data);
    logic [16:0] off_hi;
    logic [16:0] off_lo;
    off_hi = loc[16:0];
    off_lo = off_hi + 17'd2;
    save_model[int'(off_hi[16:1])] = data[31:16];
    save_model[int'(off_lo[16:1])] = data[15:0];
    save_locs.push_back(loc);
    bus_write({4'(`BRIDGE_REGION_SAVE), loc}, data);
  endtask

  function automatic logic [31:0] save_word(input logic [27:0] loc);
    logic [16:0] off_hi;
    logic [16:0] off_lo;
    off_hi = loc[16:0];
    off_lo = off_hi + 17'd2;
    return {save_model[int'(off_hi[16:1])], save_model[int'(off_lo[16:1])]};
  endfunction

  task automatic read_back_save(input int count);
    logic [31:0] got;
    for (int i = 0; i < count && i < save_locs.size(); i++) begin
      bus_read({4'(`BRIDGE_REGION_SAVE), save_locs[i]}, got);
      check_rd_data(got, save_word(save_locs[i]));
    end
  endtask

  task automatic begin_test();
    test_checks = checks;
    test_errors = errors;
  endtask

  task automatic end_test(input string name);
    $display("test %s: %0d checks, %0d errors", name, checks - test_checks,
             errors - test_errors);
  endtask

  //////////////////////////////////////////////////////////////////////
  // tests
  //////////////////////////////////////////////////////////////////////

  task automatic save_round_trip();
    logic [31:0] data;
    // word aligned, upper bits are outside the save ram
    for (int i = 0; i < n_save; i++) begin
      data = $random(seed);
      write_save_word(28'($random(seed)) & 28'hfff_fffc, data);
    end
    read_back_save(n_save);
  endtask

  task automatic rom_write_burst();
    logic [27:0]               loc;
    logic [31:0]               data;
    logic [`ROM_ADDR_BITS-1:0] off;
    rom_write_t                exp;
    for (int i = 0; i < n_rom; i++) begin
      loc  = 28'($random(seed)) & 28'hfff_fffe;
      data = $random(seed);
      off  = loc[`ROM_ADDR_BITS-1:0];
      exp  = '{en: 1'b1, addr: off, data: data[31:16]};
      rom_exp.push_back(exp);
      exp.addr = off + `ROM_ADDR_BITS'(2);
      exp.data = data[15:0];
      rom_exp.push_back(exp);
      bus_write({4'(`BRIDGE_REGION_ROM), loc}, data);
      // both halfwords are due before the next access
      checks++;
      if (rom_exp.size() != 0) begin
        errors++;
        $display("rom write %0d is missing %0d halfword writes", i, rom_exp.size());
        rom_exp.delete();
      end
    end
  endtask

  task automatic rom_type_access();
    logic [31:0] data;
    logic [31:0] got;
    for (int i = 0; i < n_type; i++) begin
      data = $random(seed);
      bus_write(`CONFIG_ADDR_ROM_TYPE, data);
      rom_type_model = data[2:0];
      check_rom_type(rom_type, rom_type_model);
      bus_read(`CONFIG_ADDR_ROM_TYPE, got);
      check_rd_data(got, {29'd0, rom_type_model});
      // save size is read only
      bus_write(`CONFIG_ADDR_SAVE_SIZE, $random(seed));
      check_rom_type(rom_type, rom_type_model);
    end
  endtask

  task automatic size_and_unmapped();
    logic [3:0]  size;
    logic [3:0]  region;
    logic [31:0] rnd;
    logic [31:0] got;
    for (int i = 0; i < n_size; i++) begin
      size = 4'({$random(seed)} % 9);
      @(posedge clk_74a);
      sram_size <= size;
      bus_read(`CONFIG_ADDR_SAVE_SIZE, got);
      check_rd_data(got, 32'(`SAVE_SIZE_BASE) << size);
      // regions 3 to 15 have no responder
      region = 4'd3 + 4'({$random(seed)} % 13);
      bus_read({region, 28'($random(seed))}, got);
      check_rd_data(got, 32'd0);
      // config offset that is never 0x0 or 0x4
      rnd = $random(seed);
      bus_read({4'(`BRIDGE_REGION_CONFIG), rnd[27:4], 4'h8}, got);
      check_rd_data(got, 32'd0);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // main sequence and watchdog
  //////////////////////////////////////////////////////////////////////

  initial begin
    seed           = 64;
    checks         = 0;
    errors         = 0;
    reset_n        = 1'b0;
    bridge_req     = '0;
    sram_size      = 4'd0;
    rom_type_model = '0;
    repeat (2) @(posedge clk_74a);
    reset_n <= 1'b1;
    @(negedge clk_74a);

    begin_test();
    check_rd_data(bridge_rd_data, 32'd0);
    check_rom_write(rom_write, '0);
    check_rom_type(rom_type, '0);
    end_test("reset");

    begin_test();
    save_round_trip();
    end_test("save round trip");

    begin_test();
    rom_write_burst();
    end_test("rom writes");

    begin_test();
    rom_type_access();
    end_test("rom type");

    begin_test();
    size_and_unmapped();
    read_back_save(n_recheck);
    end_test("save size and unmapped reads");

    $display("total: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

  initial begin
    #(timeout_ns);
    $display("watchdog expired after %0d ns before the tests finished", timeout_ns);
    $display("Something failed");
    $finish;
  end

endmodule

/* logic/core_bridge_top.sv */
// bridge side data path, all on clk_74a
// write path has the rom and save loaders, read path the save unloader
// and config registers, joined by the read mux
// save ram is internal, rom writes leave through rom_write
`timescale 1ns/1ps
`include "bridge_params.svh"

module core_bridge_top (
  input  logic                    clk_74a,
  input  logic                    reset_n,
  input  bridge_pkg::bridge_req_t bridge_req,
  input  logic [3:0]              sram_size,
  output logic [31:0]             bridge_rd_data,
  output bridge_pkg::rom_write_t  rom_write,
  output bridge_pkg::rom_type_t   rom_type
);

  import bridge_pkg::*;

  save_write_t save_wr;
  save_read_t  save_read;
  logic [15:0] save_rd_data;
  logic        save_rd;
  logic        config_rd;
  rd_result_t  save_result;
  rd_result_t  config_result;

  //////////////////////////////////////////////////////////////////////
  // write path
  //////////////////////////////////////////////////////////////////////

  bridge_loader #(
    .region    (4'(`BRIDGE_REGION_ROM)),
    .addr_bits (`ROM_ADDR_BITS),
    .write_t   (rom_write_t)
  ) u_rom_loader (
    .clk_74a    (clk_74a),
    .reset_n    (reset_n),
    .bridge_req (bridge_req),
    .mem_write  (rom_write)
  );

  bridge_loader #(
    .region    (4'(`BRIDGE_REGION_SAVE)),
    .addr_bits (`SAVE_ADDR_BITS),
    .write_t   (save_write_t)
  ) u_save_loader (
    .clk_74a    (clk_74a),
    .reset_n    (reset_n),
    .bridge_req (bridge_req),
    .mem_write  (save_wr)
  );

  save_ram u_save_ram (
    .clk_74a (clk_74a),
    .wr      (save_wr),
    .rd      (save_read),
    .rd_data (save_rd_data)
  );

  //////////////////////////////////////////////////////////////////////
  // read path
  //////////////////////////////////////////////////////////////////////

  save_unloader u_save_unloader (
    .clk_74a  (clk_74a),
    .reset_n  (reset_n),
    .save_rd  (save_rd),
    .rd_addr  (bridge_req.addr),
    .mem_read (save_read),
    .mem_data (save_rd_data),
    .result   (save_result)
  );

  config_regs u_config_regs (
    .clk_74a    (clk_74a),
    .reset_n    (reset_n),
    .bridge_req (bridge_req),
    .config_rd  (config_rd),
    .sram_size  (sram_size),
    .rom_type   (rom_type),
    .result     (config_result)
  );

  bridge_read_mux u_read_mux (
    .clk_74a        (clk_74a),
    .reset_n        (reset_n),
    .bridge_req     (bridge_req),
    .save_rd        (save_rd),
    .config_rd      (config_rd),
    .save_result    (save_result),
    .config_result  (config_result),
    .bridge_rd_data (bridge_rd_data)
  );

endmodule

/* logic/bridge_read_mux.sv */
// read side of the bridge
// decodes the region of a read and strobes one responder in the same cycle
// unmapped reads answer zero on the configuration schedule
`timescale 1ns/1ps
`include "bridge_params.svh"

module bridge_read_mux (
  input  logic                    clk_74a,
  input  logic                    reset_n,
  input  bridge_pkg::bridge_req_t bridge_req,
  output logic                    save_rd,
  output logic                    config_rd,
  input  bridge_pkg::rd_result_t  save_result,
  input  bridge_pkg::rd_result_t  config_result,
  output logic [31:0]             bridge_rd_data
);

  import bridge_pkg::*;

  logic [3:0]  region;
  logic        unmapped_rd;
  logic        unmapped_q;
  logic [31:0] rd_data_q;

  //////////////////////////////////////////////////////////////////////
  // region decode
  //////////////////////////////////////////////////////////////////////

  assign region = bridge_req.addr[31:28];

  // rom region has no read path and counts as unmapped
  always_comb begin
    save_rd     = 1'b0;
    config_rd   = 1'b0;
    unmapped_rd = 1'b0;
    if (bridge_req.rd) begin
      case (region)
        4'(`BRIDGE_REGION_SAVE):   save_rd     = 1'b1;
        4'(`BRIDGE_REGION_CONFIG): config_rd   = 1'b1;
        default:                   unmapped_rd = 1'b1;
      endcase
    end
  end

  //////////////////////////////////////////////////////////////////////
  // result latch
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_74a or negedge reset_n) begin
    if (!reset_n) begin
      unmapped_q <= 1'b0;
      rd_data_q  <= '0;
    end else begin
      // own zero answer lines up with config results
      unmapped_q <= unmapped_rd;
      if (save_result.valid) begin
        rd_data_q <= save_result.data;
      end else if (config_result.valid) begin
        rd_data_q <= config_result.data;
      end else if (unmapped_q) begin
        rd_data_q <= '0;
      end
    end
  end

  // holds until the next answer
  assign bridge_rd_data = rd_data_q;

  // responders never answer in the same cycle
  a_one_result: assert property (@(posedge clk_74a) disable iff (!reset_n)
    !(save_result.valid && config_result.valid));

endmodule

/* logic/config_regs.sv */
// configuration registers in region 0
// rom type at 0x0 is read and write, save size at 0x4 is read only
// any other configuration address reads as zero
`timescale 1ns/1ps
`include "bridge_params.svh"

module config_regs (
  input  logic                    clk_74a,
  input  logic                    reset_n,
  input  bridge_pkg::bridge_req_t bridge_req,
  input  logic                    config_rd,
  input  logic [3:0]              sram_size,
  output bridge_pkg::rom_type_t   rom_type,
  output bridge_pkg::rd_result_t  result
);

  import bridge_pkg::*;

  rom_type_t   rom_type_q;
  logic        valid_q;
  logic [31:0] data_q;
  logic [31:0] rd_word;

  // read value for the current address
  always_comb begin
    case (bridge_req.addr)
      `CONFIG_ADDR_ROM_TYPE:  rd_word = {29'd0, rom_type_q};
      `CONFIG_ADDR_SAVE_SIZE: rd_word = 32'(`SAVE_SIZE_BASE) << sram_size;
      default:                rd_word = 32'd0;
    endcase
  end

  always_ff @(posedge clk_74a or negedge reset_n) begin
    if (!reset_n) begin
      rom_type_q <= '0;
      valid_q    <= 1'b0;
    end else begin
      // only the low three bits are kept
      if (bridge_req.wr && (bridge_req.addr == `CONFIG_ADDR_ROM_TYPE)) begin
        rom_type_q <= bridge_req.wr_data[2:0];
      end
      valid_q <= config_rd;
    end
  end

  // answer one cycle after the strobe
  always_ff @(posedge clk_74a) begin
    if (config_rd) begin
      data_q <= rd_word;
    end
  end

  assign rom_type = rom_type_q;
  assign result   = '{valid: valid_q, data: data_q};

endmodule

/* logic/bridge_loader.sv */
// splits one 32 bit bridge write into two 16 bit memory writes
// upper halfword goes first at the byte offset, lower one at offset + 2
// no back pressure, a second write in the region must wait for the first
`timescale 1ns/1ps
`include "bridge_params.svh"

module bridge_loader #(
  parameter logic [3:0] region    = 4'(`BRIDGE_REGION_ROM),
  parameter int         addr_bits = `ROM_ADDR_BITS,
  parameter type        write_t   = bridge_pkg::rom_write_t
) (
  input  logic                   clk_74a,
  input  logic                   reset_n,
  input  bridge_pkg::bridge_req_t bridge_req,
  output write_t                 mem_write
);

  import bridge_pkg::*;

  localparam int cnt_bits = $clog2(`LOADER_WRITE_SPACING + 1);

  logic                  hit;
  logic                  second_due;
  logic                  en_q;
  logic                  pending_q;
  logic [cnt_bits-1:0]   cnt_q;
  logic [addr_bits-1:0]  addr_q;
  logic [15:0]           data_q;
  logic [15:0]           lo_q;

  // write in our region
  assign hit = bridge_req.wr && (bridge_req.addr[31:28] == region);
  // counter runs out in the cycle before the second write
  assign second_due = pending_q && (cnt_q == cnt_bits'(1));

  //////////////////////////////////////////////////////////////////////
  // spacing counter
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_74a or negedge reset_n) begin
    if (!reset_n) begin
      en_q      <= 1'b0;
      pending_q <= 1'b0;
      cnt_q     <= '0;
    end else begin
      en_q <= 1'b0;
      if (hit) begin
        // first halfword goes out next cycle
        en_q      <= 1'b1;
        pending_q <= 1'b1;
        cnt_q     <= cnt_bits'(`LOADER_WRITE_SPACING);
      end else if (pending_q) begin
        cnt_q <= cnt_q - cnt_bits'(1);
        if (second_due) begin
          en_q      <= 1'b1;
          pending_q <= 1'b0;
        end
      end
    end
  end

  // address and halfwords
  always_ff @(posedge clk_74a) begin
    if (hit) begin
      addr_q <= bridge_req.addr[addr_bits-1:0];
      data_q <= bridge_req.wr_data[31:16];
      lo_q   <= bridge_req.wr_data[15:0];
    end else if (second_due) begin
      // lower halfword at the next halfword address
      addr_q <= addr_q + addr_bits'(2);
      data_q <= lo_q;
    end
  end

  always_comb begin
    mem_write      = '0;
    mem_write.en   = en_q;
    mem_write.addr = addr_q;
    mem_write.data = data_q;
  end

  // host keeps its accesses far enough apart for both halfwords
  a_no_overlap: assert property (@(posedge clk_74a) disable iff (!reset_n)
    hit |-> !pending_q);

endmodule

/* save/save_unloader.sv */
// builds one 32 bit bridge read from two save ram halfword reads
// upper halfword read in cycle 1, lower in cycle 2, result valid in cycle 4
// expects the save ram to answer one cycle after each read
`timescale 1ns/1ps
`include "bridge_params.svh"

module save_unloader (
  input  logic                   clk_74a,
  input  logic                   reset_n,
  input  logic                   save_rd,
  input  logic [31:0]            rd_addr,
  output bridge_pkg::save_read_t mem_read,
  input  logic [15:0]            mem_data,
  output bridge_pkg::rd_result_t result
);

  import bridge_pkg::*;

  // step_q[0] upper read, [1] lower read, [2] last halfword back
  logic [2:0]                  step_q;
  logic                        valid_q;
  logic                        busy;
  logic [`SAVE_ADDR_BITS-1:0]  addr_q;
  logic [31:0]                 word_q;

  assign busy = (|step_q) || valid_q;

  //////////////////////////////////////////////////////////////////////
  // sequencer
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_74a or negedge reset_n) begin
    if (!reset_n) begin
      step_q  <= '0;
      valid_q <= 1'b0;
    end else begin
      step_q  <= {step_q[1:0], save_rd};
      // word complete after the lower halfword lands
      valid_q <= step_q[2];
    end
  end

  // read address, lower halfword one step on
  always_ff @(posedge clk_74a) begin
    if (save_rd) begin
      addr_q <= rd_addr[`SAVE_ADDR_BITS-1:0];
    end else if (step_q[0]) begin
      addr_q <= addr_q + `SAVE_ADDR_BITS'(2);
    end
  end

  // halfwords shift in upper first
  always_ff @(posedge clk_74a) begin
    if (step_q[1] || step_q[2]) begin
      word_q <= {word_q[15:0], mem_data};
    end
  end

  assign mem_read = '{en: step_q[0] || step_q[1], addr: addr_q};
  assign result   = '{valid: valid_q, data: word_q};

  // host spacing keeps reads off a busy sequencer
  a_not_busy: assert property (@(posedge clk_74a) disable iff (!reset_n)
    save_rd |-> !busy);

endmodule

/* save/save_ram.sv */
// halfword save memory, one write port and one read port
// byte addressed, bit 0 of both addresses is ignored
// read data comes one cycle after the read, a same cycle write is not seen
`timescale 1ns/1ps

module save_ram (
  input  logic                    clk_74a,
  input  bridge_pkg::save_write_t wr,
  input  bridge_pkg::save_read_t  rd,
  output logic [15:0]             rd_data
);

  // width taken from the port type
  localparam int addr_bits = $bits(rd.addr);
  localparam int depth     = 2 ** (addr_bits - 1);

  logic [15:0] mem [depth];
  logic [15:0] rd_data_q;

  // write port
  always_ff @(posedge clk_74a) begin
    if (wr.en) begin
      mem[wr.addr[addr_bits-1:1]] <= wr.data;
    end
  end

  // read port, old data on a collision
  always_ff @(posedge clk_74a) begin
    if (rd.en) begin
      rd_data_q <= mem[rd.addr[addr_bits-1:1]];
    end
  end

  // holds between reads
  assign rd_data = rd_data_q;

endmodule

/* common/bridge_pkg.sv */
// types for the bridge data path
// data is big endian, so the upper halfword sits at the lower address
// address field widths come from the params header
`include "bridge_params.svh"

package bridge_pkg;

  //////////////////////////////////////////////////////////////////////
  // host side
  //////////////////////////////////////////////////////////////////////

  // one bridge cycle, rd and wr are single cycle pulses
  typedef struct packed {
    logic [31:0] addr;
    logic        rd;
    logic        wr;
    logic [31:0] wr_data;
  } bridge_req_t;

  // one answer to a bridge read
  typedef struct packed {
    logic        valid;
    logic [31:0] data;
  } rd_result_t;

  //////////////////////////////////////////////////////////////////////
  // memory side
  //////////////////////////////////////////////////////////////////////

  // halfword write into rom space
  typedef struct packed {
    logic                       en;
    logic [`ROM_ADDR_BITS-1:0]  addr;
    logic [15:0]                data;
  } rom_write_t;

  // halfword write into the save ram
  typedef struct packed {
    logic                       en;
    logic [`SAVE_ADDR_BITS-1:0] addr;
    logic [15:0]                data;
  } save_write_t;

  // halfword read from the save ram
  typedef struct packed {
    logic                       en;
    logic [`SAVE_ADDR_BITS-1:0] addr;
  } save_read_t;

  // cartridge mapping type
  typedef logic [2:0] rom_type_t;

endpackage

/* common/bridge_params.svh */
// constants shared by the bridge data path
// region codes are matched against bridge address bits 31:28
// the host must leave at least 16 cycles between accesses
`ifndef BRIDGE_PARAMS_SVH
`define BRIDGE_PARAMS_SVH

// top nibble of the bridge address
`define BRIDGE_REGION_CONFIG 0
`define BRIDGE_REGION_ROM 1
`define BRIDGE_REGION_SAVE 2

// byte address widths inside a region
`define ROM_ADDR_BITS 25
`define SAVE_ADDR_BITS 17

// cycles between the two halfword writes of one word
`define LOADER_WRITE_SPACING 7

// save size in bytes for sram_size of zero
`define SAVE_SIZE_BASE 1024

// configuration register addresses
`define CONFIG_ADDR_ROM_TYPE 32'h0000_0000
`define CONFIG_ADDR_SAVE_SIZE 32'h0000_0004

`endif
